// File: bench/tilemapChecker.sv
`timescale 1ns/1ps

module tilemapChecker #(
	parameter int queueDepth = 4
) (
	input logic CLK_6M,
	input logic arstN,
	input logic hsync,
	input logic vsync,
	input logic cpuValid,
	input videoPkg::cpuReq cpuIn,
	input logic cpuReady,
	input logic rspValid,
	input videoPkg::cpuRsp cpuOut,
	input logic recValid,
	input logic recReady,
	input tilePkg::patternRec recOut,
	input logic [7:0] dropCount,
	input logic [7:0] expData,
	input logic checkOn,
	input logic [2:0] testNum,
	input logic testEnd,
	output int errCount,
	output int recChecked
);

	// raster position of one issued record
	typedef struct packed {
		logic [videoPkg::hWidth-1:0] h;
		logic [videoPkg::vWidth-1:0] v;
	} issuePos;

	// shadow state
	logic [7:0] shRam [1 << videoPkg::ramAddrWidth];
	tilePkg::scrollSet shScroll [2];
	logic [videoPkg::hWidth-1:0] hCnt;
	logic [videoPkg::vWidth-1:0] vCnt;
	logic hsD;
	logic vsD;
	logic [1:0] phase;
	logic pendRd;
	logic [7:0] pendExp;
	logic push;
	logic pop;
	// positions of the records the queue should hold, oldest first
	issuePos posQ [$];
	issuePos headPos;
	int occ;
	int expDrop;
	int testErr;

	task automatic report(input string msg);
		$display("Fail %0t: %s", $time, msg);
		errCount = errCount + 1;
		testErr = testErr + 1;
	endtask

	// group start plus scroll, bytes from the shadow tilemap
	function automatic logic [13:0] expPat(input tilePkg::patternRec r);
		logic [videoPkg::hWidth-1:0] sh;
		logic [videoPkg::vWidth-1:0] sv;
		logic [12:0] base;
		sh = {r.hPos[8:2], 2'b00} + shScroll[r.layer].hScroll;
		sv = r.vPos + shScroll[r.layer].vScroll;
		base = {r.layer, sv[7:3], sh[8:3], 1'b0};
		return {shRam[base | 13'd1][1:0], shRam[base], sv[2:0], sh[2]};
	endfunction

	initial begin
		errCount = 0;
		recChecked = 0;
		testErr = 0;
	end

	//////////////////////////////
	// sampling at the falling edge
	//////////////////////////////
	always @(negedge CLK_6M) begin
		if (!arstN) begin
			hCnt = '0;
			vCnt = '0;
			hsD = 1'b0;
			vsD = 1'b0;
			pendRd = 1'b0;
			occ = 0;
			expDrop = 0;
			posQ.delete();
			shScroll[0] = '0;
			shScroll[1] = '0;
		end else begin
			phase = hCnt[1:0];
			if (testNum == 3'd1 && (recValid || rspValid || cpuReady || dropCount != 0))
				report("outputs not idle after reset");

			// cpu side
			if (cpuValid && cpuIn.isReg && !cpuReady)
				report("register write was not accepted at once");
			if (cpuValid && cpuReady && !cpuIn.isReg && !phase[1])
				report("ram access granted during a fetch phase");
			if (rspValid !== pendRd)
				report("rspValid not one cycle after the read");
			else if (pendRd && cpuOut.rdData !== pendExp)
				report($sformatf("read data %h, expected %h", cpuOut.rdData, pendExp));
			pendRd = 1'b0;
			if (cpuValid && cpuReady && !cpuIn.isReg) begin
				if (cpuIn.write) begin
					shRam[cpuIn.addr[12:0]] = cpuIn.data;
				end else begin
					pendRd = 1'b1;
					pendExp = expData;
					if (shRam[cpuIn.addr[12:0]] !== expData)
						report("table read value differs from the shadow tilemap");
				end
			end
			if (cpuValid && cpuReady && cpuIn.isReg && cpuIn.write) begin
				case (cpuIn.addr[1:0])
					2'd0: shScroll[cpuIn.addr[2]].hScroll[7:0] = cpuIn.data;
					2'd1: begin
						shScroll[cpuIn.addr[2]].hScroll[8] = cpuIn.data[0];
						shScroll[cpuIn.addr[2]].pri = cpuIn.data[3:1];
					end
					2'd2: shScroll[cpuIn.addr[2]].vScroll = cpuIn.data;
					default: ;
				endcase
			end

			//////////////////////////////
			// output queue model
			//////////////////////////////
			push = (phase == 2'd3);
			pop = recValid && recReady;
			if (dropCount !== 8'(expDrop))
				report($sformatf("dropCount %0d, expected %0d", dropCount, expDrop));
			if (recValid !== (occ != 0))
				report("recValid does not match queue occupancy");
			if (pop && posQ.size() != 0) begin
				headPos = posQ.pop_front();
				if (recOut.hPos !== headPos.h || recOut.vPos !== headPos.v ||
					recOut.layer !== headPos.h[2])
					report($sformatf("record from h %0d v %0d, expected h %0d v %0d",
						recOut.hPos, recOut.vPos, headPos.h, headPos.v));
				if (checkOn) begin
					recChecked = recChecked + 1;
					if (recOut.patAddr !== expPat(recOut))
						report($sformatf("patAddr %h, expected %h", recOut.patAddr,
							expPat(recOut)));
					if (recOut.pri !== shScroll[recOut.layer].pri)
						report($sformatf("pri %0d, expected %0d", recOut.pri,
							shScroll[recOut.layer].pri));
				end
			end
			if (push && occ != queueDepth)
				posQ.push_back({hCnt, vCnt});
			if (push && occ == queueDepth && expDrop < 255)
				expDrop = expDrop + 1;
			occ = occ + ((push && occ != queueDepth) ? 1 : 0) - (pop ? 1 : 0);

			// raster state after the coming edge
			vCnt = (vsync && !vsD) ? '0 : (hsync && !hsD) ? vCnt + 1'b1 : vCnt;
			vsD = vsync;
			hCnt = (hsync && !hsD) ? '0 : hCnt + 1'b1;
			hsD = hsync;

			if (testEnd) begin
				$display("test %0d finished, %0d errors", testNum, testErr);
				testErr = 0;
			end
		end
	end

endmodule

// File: bench/tilemapGenTb.sv
`timescale 1ns/1ps

module tilemapGenTb;

	localparam int queueDepth = 4;
	localparam int lineLen = 64;
	localparam int frameLen = 512;
	localparam int fillLen = 8192;
	localparam int rowCount = 12;
	localparam int frameCount = 6;
	// four clocks at most per cpu access, two frames of slack per frame run
	localparam int cycleLimit = (fillLen + rowCount) * 4 + frameCount * frameLen * 2;

	// test number, request, expected read byte
	typedef struct packed {
		logic [2:0] tst;
		videoPkg::cpuReq req;
		logic [7:0] expData;
	} stimRow;

	//////////////////////////////
	// stimulus table
	//////////////////////////////
	localparam stimRow stim [rowCount] = '{
		{3'd2, 1'b0, 1'b1, 14'h0005, 8'h3c, 8'h00},
		{3'd2, 1'b0, 1'b1, 14'h1ffe, 8'ha5, 8'h00},
		{3'd2, 1'b0, 1'b0, 14'h0005, 8'h00, 8'h3c},
		{3'd2, 1'b0, 1'b0, 14'h1ffe, 8'h00, 8'ha5},
		// untouched fill byte
		{3'd2, 1'b0, 1'b0, 14'h0100, 8'h00, 8'h08},
		// layer 0 h low, ctrl with pri 5 and hHigh, v scroll
		{3'd4, 1'b1, 1'b1, 14'h0000, 8'h2d, 8'h00},
		{3'd4, 1'b1, 1'b1, 14'h0001, 8'h0b, 8'h00},
		{3'd4, 1'b1, 1'b1, 14'h0002, 8'h13, 8'h00},
		// layer 1, pri 3, no hHigh
		{3'd4, 1'b1, 1'b1, 14'h0004, 8'h80, 8'h00},
		{3'd4, 1'b1, 1'b1, 14'h0005, 8'h06, 8'h00},
		{3'd4, 1'b1, 1'b1, 14'h0006, 8'hf1, 8'h00},
		// index 3 has no register
		{3'd4, 1'b1, 1'b1, 14'h0007, 8'hff, 8'h00}
	};

	logic CLK_6M;
	logic arstN;
	logic hsync;
	logic vsync;
	logic cpuValid;
	videoPkg::cpuReq cpuIn;
	logic recReady;
	logic cpuReady;
	logic rspValid;
	videoPkg::cpuRsp cpuOut;
	logic recValid;
	tilePkg::patternRec recOut;
	logic [7:0] dropCount;
	logic [7:0] expData;
	logic checkOn;
	logic [2:0] testNum;
	logic testEnd;
	int errCount;
	int recChecked;
	int syncCnt;
	int cycles;
	int seed;

	tilemapGen #(
		.queueDepth(queueDepth)
	) tilemapGen_inst (
		.CLK_6M(CLK_6M), .arstN(arstN), .hsync(hsync), .vsync(vsync),
		.cpuValid(cpuValid), .cpuIn(cpuIn), .recReady(recReady),
		.cpuReady(cpuReady), .rspValid(rspValid), .cpuOut(cpuOut),
		.recValid(recValid), .recOut(recOut), .dropCount(dropCount)
	);

	tilemapChecker #(
		.queueDepth(queueDepth)
	) checkerInst (
		.CLK_6M(CLK_6M), .arstN(arstN), .hsync(hsync), .vsync(vsync),
		.cpuValid(cpuValid), .cpuIn(cpuIn), .cpuReady(cpuReady),
		.rspValid(rspValid), .cpuOut(cpuOut),
		.recValid(recValid), .recReady(recReady), .recOut(recOut),
		.dropCount(dropCount), .expData(expData), .checkOn(checkOn),
		.testNum(testNum), .testEnd(testEnd), .errCount(errCount),
		.recChecked(recChecked)
	);

	initial begin
		CLK_6M = 1'b0;
		forever #50 CLK_6M = ~CLK_6M;
	end

	// one clock sync pulses with vsync on every eighth line
	always @(posedge CLK_6M) begin
		#10;
		if (arstN) begin
			hsync = (syncCnt % lineLen) == 0;
			vsync = (syncCnt % frameLen) == 0;
			syncCnt = syncCnt + 1;
		end
	end

	//////////////////////////////
	// helpers
	//////////////////////////////
	function automatic logic [7:0] fillByte(input logic [12:0] a);
		return a[7:0] ^ {a[12:8], a[12:10]};
	endfunction

	task automatic waitCycles(input int n);
		repeat (n) @(posedge CLK_6M);
		#10;
	endtask

	// hold the request until the port takes it
	task automatic sendReq(input videoPkg::cpuReq req, input logic [7:0] exp);
		cpuIn = req;
		expData = exp;
		cpuValid = 1'b1;
		do @(negedge CLK_6M); while (!cpuReady);
		@(posedge CLK_6M);
		#10;
		cpuValid = 1'b0;
	endtask

	task automatic applyRows(input logic [2:0] t);
		for (int i = 0; i < rowCount; i++) begin
			if (stim[i].tst == t) begin
				sendReq(stim[i].req, stim[i].expData);
			end
		end
	endtask

	task automatic finishTest();
		testEnd = 1'b1;
		waitCycles(1);
		testEnd = 1'b0;
		testNum = testNum + 1'b1;
	endtask

	//////////////////////////////
	// test sequence
	//////////////////////////////
	initial begin
		videoPkg::cpuReq fillReq;
		int rnd;
		arstN = 1'b0;
		hsync = 1'b0;
		vsync = 1'b0;
		cpuValid = 1'b0;
		cpuIn = '0;
		recReady = 1'b1;
		expData = '0;
		checkOn = 1'b0;
		testNum = 3'd1;
		testEnd = 1'b0;
		syncCnt = 0;
		seed = 32'h2b09_fa1a;
		repeat (5) @(posedge CLK_6M);
		#10;
		arstN = 1'b1;
		finishTest();

		// fill the whole tilemap, then the table reads
		for (int a = 0; a < fillLen; a++) begin
			fillReq = {1'b0, 1'b1, 1'b0, 13'(a), fillByte(13'(a))};
			sendReq(fillReq, 8'h00);
		end
		applyRows(3'd2);
		finishTest();

		// zero scroll
		checkOn = 1'b1;
		waitCycles(frameLen);
		finishTest();

		// scroll change with old records flushed before checking resumes
		checkOn = 1'b0;
		applyRows(3'd4);
		waitCycles(16);
		checkOn = 1'b1;
		waitCycles(frameLen);
		finishTest();

		// random back-pressure, then a full stall
		repeat (frameLen) begin
			rnd = $random(seed);
			recReady = rnd[0];
			waitCycles(1);
		end
		recReady = 1'b0;
		waitCycles(64);
		recReady = 1'b1;
		waitCycles(16);
		finishTest();

		$display("tests %0d, records checked %0d, errors %0d", testNum - 1, recChecked, errCount);
		if (errCount == 0 && recChecked > 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	// run limit
	initial begin
		cycles = 0;
		while (cycles < cycleLimit) begin
			@(posedge CLK_6M);
			cycles = cycles + 1;
		end
		$display("run stopped after %0d cycles, the test sequence did not finish", cycles);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

// File: design/cpuPort.sv
`timescale 1ns/1ps

module cpuPort (
	input logic CLK_6M,
	input logic arstN,
	input logic cpuValid,
	input videoPkg::cpuReq cpuIn,
	input logic [1:0] phase,
	input logic [videoPkg::ramAddrWidth-1:0] fetchAddr,
	input logic [7:0] ramRdData,
	output logic cpuReady,
	output logic rspValid,
	output videoPkg::cpuRsp cpuOut,
	output tilePkg::scrollSet [videoPkg::layerCount-1:0] scroll,
	output logic [videoPkg::ramAddrWidth-1:0] ramAddr,
	output logic [7:0] ramWrData,
	output logic ramWe
);

	logic ramOwn;
	logic regAccept;
	logic ramAccept;
	logic regLayer;
	tilePkg::regByte wrByte;

	// cpu owns the ram in phases 2 and 3
	assign ramOwn = phase[1];

	// registers always ready, ram only in free phases
	assign cpuReady = cpuValid && (cpuIn.isReg || ramOwn);
	assign regAccept = cpuReady && cpuIn.isReg;
	assign ramAccept = cpuReady && !cpuIn.isReg;

	// bit 2 picks the layer
	assign regLayer = cpuIn.addr[2];
	assign wrByte.full = cpuIn.data;

	//////////////////////////////
	// scroll register file
	//////////////////////////////
	always_ff @(posedge CLK_6M or negedge arstN) begin
		if (!arstN) begin
			scroll <= '0;
		end else if (regAccept && cpuIn.write) begin
			case (cpuIn.addr[1:0])
				tilePkg::idxHLow: scroll[regLayer].hScroll[7:0] <= wrByte.full;
				tilePkg::idxCtrl: begin
					// high scroll bit and priority share one byte
					scroll[regLayer].hScroll[8] <= wrByte.ctrl.hHigh;
					scroll[regLayer].pri <= wrByte.ctrl.pri;
				end
				tilePkg::idxVScroll: scroll[regLayer].vScroll <= wrByte.full;
				// index 3 unused
				default: ;
			endcase
		end
	end

	//////////////////////////////
	// ram arbitration
	//////////////////////////////
	// fetch address in phases 0 and 1
	assign ramAddr = ramOwn ? cpuIn.addr[videoPkg::ramAddrWidth-1:0] : fetchAddr;
	assign ramWrData = cpuIn.data;
	assign ramWe = ramAccept && cpuIn.write;

	// read data arrives one clock after the grant
	always_ff @(posedge CLK_6M or negedge arstN) begin
		if (!arstN) begin
			rspValid <= 1'b0;
		end else begin
			rspValid <= ramAccept && !cpuIn.write;
		end
	end
	assign cpuOut.rdData = ramRdData;

	// a waiting request holds still until the free phase grants it
	assert property (@(posedge CLK_6M) disable iff (!arstN)
		cpuValid && !cpuReady |=> cpuValid && $stable(cpuIn));

endmodule

// File: design/patternQueue.sv
`timescale 1ns/1ps

module patternQueue #(
	parameter int queueDepth = 4
) (
	input logic CLK_6M,
	input logic arstN,
	input logic recPush,
	input tilePkg::patternRec recData,
	input logic recReady,
	output logic recValid,
	output tilePkg::patternRec recOut,
	output logic [7:0] dropCount
);

	localparam int ptrWidth = (queueDepth > 1) ? $clog2(queueDepth) : 1;
	localparam int cntWidth = $clog2(queueDepth + 1);

	tilePkg::patternRec store [queueDepth];
	logic [ptrWidth-1:0] wrPtr;
	logic [ptrWidth-1:0] rdPtr;
	logic [cntWidth-1:0] count;
	logic full;
	logic push;
	logic pop;
	logic drop;

	// wrap for any depth
	function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] ptr);
		if (ptr == ptrWidth'(queueDepth - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	// raster cannot wait, so a full queue loses the record
	assign full = (count == cntWidth'(queueDepth));
	assign push = recPush && !full;
	assign drop = recPush && full;
	assign pop = recValid && recReady;

	assign recValid = (count != '0);
	assign recOut = store[rdPtr];

	//////////////////////////////
	// storage
	//////////////////////////////
	always_ff @(posedge CLK_6M) begin
		if (push) begin
			store[wrPtr] <= recData;
		end
	end

	//////////////////////////////
	// pointers and counters
	//////////////////////////////
	always_ff @(posedge CLK_6M or negedge arstN) begin
		if (!arstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			dropCount <= '0;
		end else begin
			if (push) begin
				wrPtr <= nextPtr(wrPtr);
			end
			if (pop) begin
				rdPtr <= nextPtr(rdPtr);
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
			// saturate at 255
			if (drop && dropCount != 8'hFF) begin
				dropCount <= dropCount + 1'b1;
			end
		end
	end

	// head record holds while stalled
	assert property (@(posedge CLK_6M) disable iff (!arstN)
		recValid && !recReady |=> recValid && $stable(recOut));

endmodule

// File: design/rasterCounter.sv
`timescale 1ns/1ps

module rasterCounter (
	input logic CLK_6M,
	input logic arstN,
	input logic hsync,
	input logic vsync,
	output logic [videoPkg::hWidth-1:0] hPos,
	output logic [videoPkg::vWidth-1:0] vPos
);

	logic hsyncD;
	logic vsyncD;
	logic hRise;
	logic vRise;

	// rising edges against the last sampled level
	assign hRise = hsync && !hsyncD;
	assign vRise = vsync && !vsyncD;

	//////////////////////////////
	// sync history
	//////////////////////////////
	always_ff @(posedge CLK_6M or negedge arstN) begin
		if (!arstN) begin
			hsyncD <= 1'b0;
			vsyncD <= 1'b0;
		end else begin
			hsyncD <= hsync;
			vsyncD <= vsync;
		end
	end

	//////////////////////////////
	// pixel counters
	//////////////////////////////
	always_ff @(posedge CLK_6M or negedge arstN) begin
		if (!arstN) begin
			hPos <= '0;
			vPos <= '0;
		end else begin
			// new line restarts the column
			if (hRise) begin
				hPos <= '0;
			end else begin
				hPos <= hPos + 1'b1;
			end
			// vsync wins over the line step
			if (vRise) begin
				vPos <= '0;
			end else if (hRise) begin
				vPos <= vPos + 1'b1;
			end
		end
	end

endmodule

// File: design/tileFetch.sv
`timescale 1ns/1ps

module tileFetch (
	input logic CLK_6M,
	input logic arstN,
	input logic [videoPkg::hWidth-1:0] hPos,
	input logic [videoPkg::vWidth-1:0] vPos,
	input tilePkg::scrollSet [videoPkg::layerCount-1:0] scroll,
	input logic [7:0] ramRdData,
	output logic [videoPkg::ramAddrWidth-1:0] fetchAddr,
	output logic recPush,
	output tilePkg::patternRec recData
);

	logic [1:0] phase;
	logic layer;
	tilePkg::scrollSet active;
	logic [videoPkg::hWidth-1:0] hBase;
	logic [videoPkg::hWidth-1:0] sh;
	logic [videoPkg::vWidth-1:0] sv;
	// entry byte 0 and low bits of byte 1
	logic [7:0] tileLow;
	logic [1:0] tileHigh;

	//////////////////////////////
	// slot decode
	//////////////////////////////

	// four clocks per layer, eight per tile column pair
	assign phase = hPos[1:0];
	// layer 0 first, then layer 1
	assign layer = hPos[2];
	assign active = scroll[layer];

	// scroll the start of the four clock group
	// so every phase of a group sees the same tile
	assign hBase = {hPos[videoPkg::hWidth-1:2], 2'b00};
	assign sh = hBase + active.hScroll;
	assign sv = vPos + active.vScroll;

	//////////////////////////////
	// entry reads
	//////////////////////////////

	// layer, tile row, tile column, byte select
	// byte 0 in phase 0 and byte 1 in phase 1
	assign fetchAddr = {layer, sv[7:3], sh[8:3], phase[0]};

	// ram read is registered
	// byte 0 shows up in phase 1, byte 1 in phase 2
	always_ff @(posedge CLK_6M or negedge arstN) begin
		if (!arstN) begin
			tileLow <= '0;
			tileHigh <= '0;
		end else begin
			case (phase)
				2'd1: tileLow <= ramRdData;
				2'd2: tileHigh <= ramRdData[1:0];
				default: ;
			endcase
		end
	end

	//////////////////////////////
	// record assembly
	//////////////////////////////

	// issue once both bytes are in
	assign recPush = (phase == 2'd3);

	assign recData.layer = layer;
	// priority only passes through
	assign recData.pri = active.pri;
	assign recData.hPos = hPos;
	assign recData.vPos = vPos;
	// tile number, pixel row, half of the row
	assign recData.patAddr = {tileHigh, tileLow, sv[2:0], sh[2]};

	// each issue follows the two capture slots of its own group
	assert property (@(posedge CLK_6M) disable iff (!arstN)
		recPush |-> $past(phase, 1) == 2'd2 && $past(phase, 2) == 2'd1);

endmodule

// File: design/tilePkg.sv
package tilePkg;

	//////////////////////////////
	// scroll register decoding
	//////////////////////////////

	// register index within a layer
	localparam logic [1:0] idxHLow = 2'd0;
	localparam logic [1:0] idxCtrl = 2'd1;
	localparam logic [1:0] idxVScroll = 2'd2;

	// control byte layout
	// hHigh is scroll bit 8, pri goes to the mixer
	typedef struct packed {
		logic [3:0] spare;
		logic [2:0] pri;
		logic hHigh;
	} ctrlByte;

	// same cpu byte seen as plain data or as control fields
	typedef union packed {
		logic [7:0] full;
		ctrlByte ctrl;
	} regByte;

	// per layer scroll and priority
	typedef struct packed {
		logic [videoPkg::hWidth-1:0] hScroll;
		logic [videoPkg::vWidth-1:0] vScroll;
		logic [2:0] pri;
	} scrollSet;

	//////////////////////////////
	// fetch output
	//////////////////////////////

	// one pattern rom request
	typedef struct packed {
		logic layer;
		logic [2:0] pri;
		// raster position when issued
		logic [videoPkg::hWidth-1:0] hPos;
		logic [videoPkg::vWidth-1:0] vPos;
		logic [13:0] patAddr;
	} patternRec;

endpackage

// File: design/tileRam.sv
`timescale 1ns/1ps

module tileRam (
	input logic CLK_6M,
	input logic [videoPkg::ramAddrWidth-1:0] addr,
	input logic [7:0] wrData,
	input logic we,
	output logic [7:0] rdData
);

	// both layers, 64 x 32 tiles, two bytes each
	localparam int depth = 1 << videoPkg::ramAddrWidth;

	logic [7:0] mem [depth];

	//////////////////////////////
	// storage
	//////////////////////////////

	// single port
	// write and registered read share the address
	always_ff @(posedge CLK_6M) begin
		if (we) begin
			mem[addr] <= wrData;
		end
	end

	// old data on a same cycle write
	always_ff @(posedge CLK_6M) begin
		rdData <= mem[addr];
	end

endmodule

// File: design/tilemapGen.sv
`timescale 1ns/1ps

module tilemapGen #(
	parameter int queueDepth = 4
) (
	input logic CLK_6M,
	input logic arstN,
	input logic hsync,
	input logic vsync,
	input logic cpuValid,
	input videoPkg::cpuReq cpuIn,
	input logic recReady,
	output logic cpuReady,
	output logic rspValid,
	output videoPkg::cpuRsp cpuOut,
	output logic recValid,
	output tilePkg::patternRec recOut,
	output logic [7:0] dropCount
);

	// raster position
	logic [videoPkg::hWidth-1:0] hPos;
	logic [videoPkg::vWidth-1:0] vPos;

	// register file to fetch
	tilePkg::scrollSet [videoPkg::layerCount-1:0] scroll;

	// tilemap ram, driven through cpuPort
	logic [videoPkg::ramAddrWidth-1:0] ramAddr;
	logic [videoPkg::ramAddrWidth-1:0] fetchAddr;
	logic [7:0] ramWrData;
	logic [7:0] ramRdData;
	logic ramWe;

	// fetch to queue
	logic recPush;
	tilePkg::patternRec recData;

	//////////////////////////////
	// input side
	//////////////////////////////
	cpuPort cpuPortInst (
		.CLK_6M(CLK_6M),
		.arstN(arstN),
		.cpuValid(cpuValid),
		.cpuIn(cpuIn),
		.phase(hPos[1:0]),
		.fetchAddr(fetchAddr),
		.ramRdData(ramRdData),
		.cpuReady(cpuReady),
		.rspValid(rspValid),
		.cpuOut(cpuOut),
		.scroll(scroll),
		.ramAddr(ramAddr),
		.ramWrData(ramWrData),
		.ramWe(ramWe)
	);

	//////////////////////////////
	// processing
	//////////////////////////////
	rasterCounter rasterCounterInst (
		.CLK_6M(CLK_6M),
		.arstN(arstN),
		.hsync(hsync),
		.vsync(vsync),
		.hPos(hPos),
		.vPos(vPos)
	);

	tileRam tileRamInst (
		.CLK_6M(CLK_6M),
		.addr(ramAddr),
		.wrData(ramWrData),
		.we(ramWe),
		.rdData(ramRdData)
	);

	tileFetch tileFetchInst (
		.CLK_6M(CLK_6M),
		.arstN(arstN),
		.hPos(hPos),
		.vPos(vPos),
		.scroll(scroll),
		.ramRdData(ramRdData),
		.fetchAddr(fetchAddr),
		.recPush(recPush),
		.recData(recData)
	);

	//////////////////////////////
	// output side
	//////////////////////////////
	patternQueue #(
		.queueDepth(queueDepth)
	) patternQueueInst (
		.CLK_6M(CLK_6M),
		.arstN(arstN),
		.recPush(recPush),
		.recData(recData),
		.recReady(recReady),
		.recValid(recValid),
		.recOut(recOut),
		.dropCount(dropCount)
	);

endmodule

// File: design/videoPkg.sv
package videoPkg;

	//////////////////////////////
	// raster geometry
	//////////////////////////////

	// horizontal pixel counter width
	localparam int hWidth = 9;
	// vertical line counter width
	localparam int vWidth = 8;

	// number of scrolling layers
	localparam int layerCount = 2;

	// tilemap ram address width
	// layer, row, column and byte select
	localparam int ramAddrWidth = 13;

	//////////////////////////////
	// cpu bus
	//////////////////////////////

	// one cpu request
	// isReg picks the scroll registers over the tilemap ram
	typedef struct packed {
		logic isReg;
		logic write;
		// ram address in 12:0, register index in 2:0
		logic [13:0] addr;
		logic [7:0] data;
	} cpuReq;

	// read response
	// valid one cycle after a ram read is accepted
	typedef struct packed {
		logic [7:0] rdData;
	} cpuRsp;

endpackage

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tilemapGenTb -f vlog.f

out=$(./obj_dir/VtilemapGenTb)
echo "$out"

if echo "$out" | grep -q "Simulation PASSED"; then
	exit 0
else
	exit 1
fi

// File: vlog.f
design/videoPkg.sv
design/tilePkg.sv
design/cpuPort.sv
design/rasterCounter.sv
design/tileRam.sv
design/tileFetch.sv
design/patternQueue.sv
design/tilemapGen.sv
bench/tilemapChecker.sv
bench/tilemapGenTb.sv
